/* include/ex_cfg.svh */
// Execute stage configuration
// Datapath widths and multiplier redundancy
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Operand and result width
`define EX_XLEN 32
// Register file address width
`define EX_RADDR_W 6

////////////////////////////////////////
// Multiplier redundancy
////////////////////////////////////////

// Redundant multiplier copies feeding the voter
`define EX_MULT_COPIES 3
// Replica word, result plus multicycle, mulh_active and ready
`define EX_VOTE_W (`EX_XLEN + 3)

`endif

/* rtl/ex_pkg.sv */
// Execute stage types
// Operator encodings shared by the ALU, multiplier and stage top
package ex_pkg;

  // ALU operators, compare group at the end
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  // Multiplier operators
  // Only MUL_L completes in one cycle
  typedef enum logic [1:0] {
    MUL_L   = 2'd0,
    MUL_H   = 2'd1,
    MUL_HU  = 2'd2,
    MUL_HSU = 2'd3
  } mul_op_e;

endpackage

/* rtl/ex_alu.sv */
// Integer ALU, combinational
// Arithmetic, logic, shifts, set-less-than and branch compare
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
  input  ex_pkg::alu_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;
  logic       cmp_bit;

  // Shift amount from the low bits of operand b
  assign shamt = operand_b_i[4:0];

  // Shared comparators
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  ////////////////////////////////////////
  // Branch comparison
  ////////////////////////////////////////

  always_comb begin
    cmp_bit = 1'b0;
    case (operator_i)
      ex_pkg::ALU_EQ: cmp_bit = equal;
      ex_pkg::ALU_NE: cmp_bit = ~equal;
      ex_pkg::ALU_LT: cmp_bit = lt_signed;
      ex_pkg::ALU_GE: cmp_bit = ~lt_signed;
      default:        cmp_bit = 1'b0;
    endcase
  end

  // Non-compare operators leave the decision low
  assign cmp_result_o = cmp_bit;

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      ex_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      // Set-less-than gives 0 or 1
      ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
      // Compare group returns the decision bit zero-extended
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,
      ex_pkg::ALU_GE:   result_o = {{(`EX_XLEN-1){1'b0}}, cmp_bit};
      default:          result_o = '0;
    endcase
  end

endmodule

/* rtl/ex_mult.sv */
// Single multiplier copy
// Low product in one cycle, high products over two cycles
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  ex_pkg::mul_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                multicycle_o,
  output logic                mulh_active_o,
  output logic                ready_o
);

  typedef enum logic {
    ST_IDLE,
    ST_FINISH
  } state_e;

  state_e                       state_q;
  state_e                       state_d;
  logic                         sign_a;
  logic                         sign_b;
  logic                         start_high;
  logic signed [`EX_XLEN:0]     op_a_ext;
  logic signed [`EX_XLEN:0]     op_b_ext;
  logic signed [2*`EX_XLEN-1:0] prod_full;
  logic [`EX_XLEN-1:0]          prod_hi_q;

  // Signedness per operator
  assign sign_a = (operator_i == ex_pkg::MUL_H) || (operator_i == ex_pkg::MUL_HSU);
  assign sign_b = operator_i == ex_pkg::MUL_H;

  // One extra bit lets a single signed multiply cover all three modes
  assign op_a_ext  = {sign_a & op_a_i[`EX_XLEN-1], op_a_i};
  assign op_b_ext  = {sign_b & op_b_i[`EX_XLEN-1], op_b_i};
  assign prod_full = op_a_ext * op_b_ext;

  // High product request seen while idle
  assign start_high = (state_q == ST_IDLE) && enable_i && (operator_i != ex_pkg::MUL_L);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    result_o      = prod_full[`EX_XLEN-1:0];
    multicycle_o  = 1'b0;
    mulh_active_o = 1'b0;
    ready_o       = 1'b1;
    case (state_q)
      ST_IDLE: begin
        if (start_high) begin
          // First cycle, product is being captured
          mulh_active_o = 1'b1;
          ready_o       = 1'b0;
          state_d       = ST_FINISH;
        end
      end
      ST_FINISH: begin
        result_o     = prod_hi_q;
        multicycle_o = 1'b1;
        // Hold the high half until the stage moves on
        if (ex_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper half of the product, the only part returned later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_hi_q <= '0;
    end else if (start_high) begin
      prod_hi_q <= prod_full[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

endmodule

/* rtl/ex_mult_tmr.sv */
// Triplicated multiplier with majority voter
// Raw replica words stay visible for fault monitoring
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mult_tmr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  ex_pkg::mul_op_e       operator_i,
  input  logic [`EX_XLEN-1:0]   op_a_i,
  input  logic [`EX_XLEN-1:0]   op_b_i,
  input  logic                  ex_ready_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  multicycle_o,
  output logic                  ready_o,
  output logic [`EX_VOTE_W-1:0] replica_0_o,
  output logic [`EX_VOTE_W-1:0] replica_1_o,
  output logic [`EX_VOTE_W-1:0] replica_2_o
);

  logic [`EX_XLEN-1:0]   copy_result [`EX_MULT_COPIES];
  logic                  copy_multicycle [`EX_MULT_COPIES];
  logic                  copy_mulh_active [`EX_MULT_COPIES];
  logic                  copy_ready [`EX_MULT_COPIES];
  logic [`EX_VOTE_W-1:0] copy_word [`EX_MULT_COPIES];
  logic [`EX_VOTE_W-1:0] voted_word;

  for (genvar i = 0; i < `EX_MULT_COPIES; i++) begin : g_copy
    ex_mult u_mult (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable_i     (enable_i),
      .operator_i   (operator_i),
      .op_a_i       (op_a_i),
      .op_b_i       (op_b_i),
      .ex_ready_i   (ex_ready_i),
      .result_o     (copy_result[i]),
      .multicycle_o (copy_multicycle[i]),
      .mulh_active_o(copy_mulh_active[i]),
      .ready_o      (copy_ready[i])
    );
    // Status bits sit below the result
    assign copy_word[i] = {copy_result[i], copy_multicycle[i], copy_mulh_active[i],
                           copy_ready[i]};
  end

  assign replica_0_o = copy_word[0];
  assign replica_1_o = copy_word[1];
  assign replica_2_o = copy_word[2];

  ////////////////////////////////////////
  // Majority voter
  ////////////////////////////////////////

  always_comb begin
    if (copy_word[0] == copy_word[1]) begin
      voted_word = copy_word[0];
    end else if (copy_word[1] == copy_word[2]) begin
      voted_word = copy_word[1];
    end else if (copy_word[0] == copy_word[2]) begin
      voted_word = copy_word[0];
    end else begin
      // No majority, force a stalled zero result
      voted_word = '0;
    end
  end

  // mulh_active travels in bit 1 only to take part in the vote
  assign result_o     = voted_word[`EX_VOTE_W-1:3];
  assign multicycle_o = voted_word[2];
  assign ready_o      = voted_word[0];

endmodule

/* rtl/ex_stage.sv */
// Integer execute stage top
// ALU, voted multiplier, forwarding mux, load write-back register, stall logic
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // ALU
  input  ex_pkg::alu_op_e        alu_operator_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_c_i,
  input  logic                   alu_en_i,
  // Multiplier
  input  ex_pkg::mul_op_e        mult_operator_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_b_i,
  input  logic                   mult_en_i,
  // CSR and LSU
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  // Control from ID and WB
  input  logic                   branch_in_ex_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  input  logic                   regfile_we_i,
  input  logic                   wb_ready_i,
  // Forwarding port
  output logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,
  output logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic                   regfile_alu_we_fw_o,
  // Load write-back port
  output logic [`EX_XLEN-1:0]    regfile_wdata_wb_o,
  output logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o,
  output logic                   regfile_we_wb_o,
  // Branch, multiplier status, stall
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  output logic                   mult_multicycle_o,
  output logic [`EX_VOTE_W-1:0]  mult_out_0_o,
  output logic [`EX_VOTE_W-1:0]  mult_out_1_o,
  output logic [`EX_VOTE_W-1:0]  mult_out_2_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic [`EX_XLEN-1:0]    alu_result;
  logic                   alu_cmp_result;
  logic [`EX_XLEN-1:0]    mult_result;
  logic                   mult_ready;
  logic                   lsu_we_next;
  logic                   regfile_we_lsu;
  logic [`EX_RADDR_W-1:0] regfile_waddr_lsu;

  ex_alu u_alu (
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .result_o    (alu_result),
    .cmp_result_o(alu_cmp_result)
  );

  ex_mult_tmr u_mult_tmr (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (mult_en_i),
    .operator_i  (mult_operator_i),
    .op_a_i      (mult_operand_a_i),
    .op_b_i      (mult_operand_b_i),
    .ex_ready_i  (ex_ready_o),
    .result_o    (mult_result),
    .multicycle_o(mult_multicycle_o),
    .ready_o     (mult_ready),
    .replica_0_o (mult_out_0_o),
    .replica_1_o (mult_out_1_o),
    .replica_2_o (mult_out_2_o)
  );

  ////////////////////////////////////////
  // Forwarding write port
  ////////////////////////////////////////

  // Priority CSR, then multiplier, then ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result;
    end
    if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  // Branch resolution
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////
  // Load write-back register
  ////////////////////////////////////////

  // Faulting loads never write
  assign lsu_we_next = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu    <= 1'b0;
      regfile_waddr_lsu <= '0;
    end else if (ex_valid_o) begin
      regfile_we_lsu <= lsu_we_next;
      if (lsu_we_next) begin
        regfile_waddr_lsu <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB drained with nothing new, drop the write
      regfile_we_lsu <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  // Load data arrives straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////////////////////////
  // Stall and valid
  ////////////////////////////////////////

  // Branches finish in EX without waiting on WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

/* sim/ex_stage_asserts.sv */
// Execute stage checker, bound into ex_stage
// Voter agreement, valid against ready terms, write-back state after reset
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic [`EX_VOTE_W-1:0] rep_0_i,
  input logic [`EX_VOTE_W-1:0] rep_1_i,
  input logic [`EX_VOTE_W-1:0] rep_2_i,
  input logic                  ex_valid_i,
  input logic                  lsu_ready_i,
  input logic                  wb_ready_i,
  input logic                  we_wb_i
);

  // Fault-free copies see identical inputs
  replicas_agree: assert property (@(posedge clk) disable iff (!rst_n)
    (rep_0_i == rep_1_i) && (rep_1_i == rep_2_i))
    else $error("multiplier replica words disagree");

  // Valid only when every multiplier copy, the LSU and WB are ready
  // Ready sits in bit 0 of each raw replica word
  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> (rep_0_i[0] && rep_1_i[0] && rep_2_i[0] && lsu_ready_i && wb_ready_i))
    else $error("ex_valid_o high while a ready term is low");

  // Write-back register comes out of reset empty
  wb_empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !we_wb_i)
    else $error("regfile_we_wb_o high right after reset release");

endmodule

/* sim/ex_stage_tb.sv */
// Execute stage testbench
// Random ALU and multiplier stimulus, CSR priority, stall and load write-back checks
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_tb;

  localparam int READY_TIMEOUT = 16;

  logic clk;
  logic rst_n;

  // DUT inputs
  ex_pkg::alu_op_e        alu_op;
  logic [`EX_XLEN-1:0]    alu_a;
  logic [`EX_XLEN-1:0]    alu_b;
  logic [`EX_XLEN-1:0]    alu_c;
  logic                   alu_en;
  ex_pkg::mul_op_e        mul_op;
  logic [`EX_XLEN-1:0]    mul_a;
  logic [`EX_XLEN-1:0]    mul_b;
  logic                   mult_en;
  logic                   csr_access;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic                   lsu_en;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   lsu_ready;
  logic                   lsu_err;
  logic                   branch_in_ex;
  logic [`EX_RADDR_W-1:0] alu_waddr;
  logic                   alu_we;
  logic [`EX_RADDR_W-1:0] rf_waddr;
  logic                   rf_we;
  logic                   wb_ready;

  // DUT outputs
  logic [`EX_XLEN-1:0]    fw_wdata;
  logic [`EX_RADDR_W-1:0] fw_waddr;
  logic                   fw_we;
  logic [`EX_XLEN-1:0]    ld_wdata;
  logic [`EX_RADDR_W-1:0] ld_waddr;
  logic                   ld_we;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   branch_decision;
  logic                   mult_multicycle;
  logic [`EX_VOTE_W-1:0]  rep_0;
  logic [`EX_VOTE_W-1:0]  rep_1;
  logic [`EX_VOTE_W-1:0]  rep_2;
  logic                   ex_ready;
  logic                   ex_valid;

  // Expectations posted on the falling edge, checked on the next rising edge
  logic                   chk_fw;
  logic [`EX_XLEN-1:0]    exp_fw;
  logic                   chk_valid;
  logic                   exp_valid;
  logic                   chk_ready;
  logic                   exp_ready;
  logic                   exp_mc;
  logic                   chk_br;
  logic                   exp_br;
  logic                   chk_rep;
  logic                   chk_wb;
  logic                   exp_we_wb;
  logic [`EX_RADDR_W-1:0] exp_waddr_wb;

  logic [31:0] rng = 32'had16_a164;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        timed_out = 1'b0;

  ex_stage DUT (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .alu_operator_i        (alu_op),
    .alu_operand_a_i       (alu_a),
    .alu_operand_b_i       (alu_b),
    .alu_operand_c_i       (alu_c),
    .alu_en_i              (alu_en),
    .mult_operator_i       (mul_op),
    .mult_operand_a_i      (mul_a),
    .mult_operand_b_i      (mul_b),
    .mult_en_i             (mult_en),
    .csr_access_i          (csr_access),
    .csr_rdata_i           (csr_rdata),
    .lsu_en_i              (lsu_en),
    .lsu_rdata_i           (lsu_rdata),
    .lsu_ready_ex_i        (lsu_ready),
    .lsu_err_i             (lsu_err),
    .branch_in_ex_i        (branch_in_ex),
    .regfile_alu_waddr_i   (alu_waddr),
    .regfile_alu_we_i      (alu_we),
    .regfile_waddr_i       (rf_waddr),
    .regfile_we_i          (rf_we),
    .wb_ready_i            (wb_ready),
    .regfile_alu_wdata_fw_o(fw_wdata),
    .regfile_alu_waddr_fw_o(fw_waddr),
    .regfile_alu_we_fw_o   (fw_we),
    .regfile_wdata_wb_o    (ld_wdata),
    .regfile_waddr_wb_o    (ld_waddr),
    .regfile_we_wb_o       (ld_we),
    .jump_target_o         (jump_target),
    .branch_decision_o     (branch_decision),
    .mult_multicycle_o     (mult_multicycle),
    .mult_out_0_o          (rep_0),
    .mult_out_1_o          (rep_1),
    .mult_out_2_o          (rep_2),
    .ex_ready_o            (ex_ready),
    .ex_valid_o            (ex_valid)
  );

  bind ex_stage ex_stage_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .rep_0_i     (mult_out_0_o),
    .rep_1_i     (mult_out_1_o),
    .rep_2_i     (mult_out_2_o),
    .ex_valid_i  (ex_valid_o),
    .lsu_ready_i (lsu_ready_ex_i),
    .wb_ready_i  (wb_ready_i),
    .we_wb_i     (regfile_we_wb_o)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Signed less-than from the sign bits, unsigned compare when signs match
  function automatic logic less_signed(logic [`EX_XLEN-1:0] a, logic [`EX_XLEN-1:0] b);
    return (a[`EX_XLEN-1] != b[`EX_XLEN-1]) ? a[`EX_XLEN-1] : (a < b);
  endfunction

  function automatic logic ref_cmp(ex_pkg::alu_op_e op, logic [`EX_XLEN-1:0] a,
                                   logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_EQ: return a == b;
      ex_pkg::ALU_NE: return a != b;
      ex_pkg::ALU_LT: return less_signed(a, b);
      ex_pkg::ALU_GE: return !less_signed(a, b);
      default:        return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] ref_alu(ex_pkg::alu_op_e op,
                                                  logic [`EX_XLEN-1:0] a,
                                                  logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      ex_pkg::ALU_SLT:  return `EX_XLEN'(less_signed(a, b));
      ex_pkg::ALU_SLTU: return `EX_XLEN'(a < b);
      default:          return `EX_XLEN'(ref_cmp(op, a, b));
    endcase
  endfunction

  // Extend to double width, the product is exact modulo 2^64
  function automatic logic [`EX_XLEN-1:0] ref_mul(ex_pkg::mul_op_e op,
                                                  logic [`EX_XLEN-1:0] a,
                                                  logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    logic [2*`EX_XLEN-1:0] p;
    ea = {{`EX_XLEN{1'b0}}, a};
    eb = {{`EX_XLEN{1'b0}}, b};
    if (op == ex_pkg::MUL_H || op == ex_pkg::MUL_HSU) begin
      ea = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    end
    if (op == ex_pkg::MUL_H) begin
      eb = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
    end
    p = ea * eb;
    return (op == ex_pkg::MUL_L) ? p[`EX_XLEN-1:0] : p[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  ////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////

  task automatic flag_mismatch(string msg);
    errors++;
    $display("[FAIL] %0t %s", $time, msg);
  endtask

  always @(posedge clk) begin
    if (chk_fw) begin
      assert (fw_wdata == exp_fw && fw_we == alu_we && fw_waddr == alu_waddr)
        else flag_mismatch($sformatf("fw port %h/%b/%0d, expected %h/%b/%0d",
                                     fw_wdata, fw_we, fw_waddr, exp_fw, alu_we, alu_waddr));
    end
    if (chk_valid) begin
      assert (ex_valid == exp_valid)
        else flag_mismatch($sformatf("ex_valid_o %b, expected %b", ex_valid, exp_valid));
    end
    if (chk_ready) begin
      assert (ex_ready == exp_ready && mult_multicycle == exp_mc)
        else flag_mismatch($sformatf("ready/multicycle %b/%b, expected %b/%b",
                                     ex_ready, mult_multicycle, exp_ready, exp_mc));
    end
    if (chk_br) begin
      assert (branch_decision == exp_br && jump_target == alu_c)
        else flag_mismatch($sformatf("branch %b target %h, expected %b target %h",
                                     branch_decision, jump_target, exp_br, alu_c));
    end
    if (chk_rep) begin
      assert (rep_0 == rep_1 && rep_1 == rep_2 && rep_0[`EX_VOTE_W-1:3] == fw_wdata)
        else flag_mismatch($sformatf("replicas %h %h %h, voted data %h",
                                     rep_0, rep_1, rep_2, fw_wdata));
    end
    if (chk_wb) begin
      assert (ld_we == exp_we_wb && ld_waddr == exp_waddr_wb && ld_wdata == lsu_rdata)
        else flag_mismatch($sformatf("wb port %b/%0d/%h, expected %b/%0d/%h", ld_we,
                                     ld_waddr, ld_wdata, exp_we_wb, exp_waddr_wb, lsu_rdata));
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic idle_inputs();
    alu_en       = 1'b0;
    mult_en      = 1'b0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    alu_we       = 1'b0;
    rf_we        = 1'b0;
    wb_ready     = 1'b1;
    lsu_ready    = 1'b1;
    chk_fw       = 1'b0;
    chk_valid    = 1'b0;
    chk_ready    = 1'b0;
    chk_br       = 1'b0;
    chk_rep      = 1'b0;
    chk_wb       = 1'b0;
  endtask

  task automatic finish_test(string name, int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  // Poll ready on rising edges, bounded by its own timeout
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!ex_ready && cycles < READY_TIMEOUT) begin
      cycles++;
      @(posedge clk);
    end
    if (!ex_ready) begin
      timed_out = 1'b1;
      $display("Timeout: ex_ready_o stayed low for %0d cycles at %0t", cycles, $time);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_alu_ops();
    int          err0;
    logic [31:0] rnd;
    err0 = errors;
    for (int k = 0; k <= 9; k++) begin
      for (int n = 0; n < 8; n++) begin
        @(negedge clk);
        rnd       = next_rand();
        alu_op    = ex_pkg::alu_op_e'(k);
        alu_a     = next_rand();
        alu_b     = next_rand();
        alu_en    = 1'b1;
        alu_we    = rnd[0];
        alu_waddr = rnd[6:1];
        exp_fw    = ref_alu(alu_op, alu_a, alu_b);
        exp_valid = 1'b1;
        chk_fw    = 1'b1;
        chk_valid = 1'b1;
      end
    end
    @(negedge clk);
    idle_inputs();
    finish_test("alu_ops", err0);
  endtask

  task automatic run_compares();
    int err0;
    err0 = errors;
    for (int k = 10; k <= 13; k++) begin
      for (int n = 0; n < 8; n++) begin
        @(negedge clk);
        alu_op       = ex_pkg::alu_op_e'(k);
        alu_a        = next_rand();
        // Every fourth pair is equal to hit EQ and GE
        alu_b        = (n % 4 == 0) ? alu_a : next_rand();
        alu_c        = next_rand();
        alu_en       = 1'b1;
        branch_in_ex = 1'b1;
        exp_br       = ref_cmp(alu_op, alu_a, alu_b);
        exp_fw       = `EX_XLEN'(exp_br);
        chk_br       = 1'b1;
        chk_fw       = 1'b1;
      end
    end
    @(negedge clk);
    idle_inputs();
    finish_test("compares", err0);
  endtask

  task automatic run_mult_ops();
    int err0;
    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 6; n++) begin
        @(negedge clk);
        mul_op    = ex_pkg::mul_op_e'(k);
        mul_a     = (n == 0) ? 32'h8000_0000 : next_rand();
        mul_b     = (n == 0) ? 32'hffff_ffff : next_rand();
        mult_en   = 1'b1;
        chk_rep   = 1'b1;
        chk_ready = 1'b1;
        exp_mc    = 1'b0;
        exp_fw    = ref_mul(mul_op, mul_a, mul_b);
        if (mul_op == ex_pkg::MUL_L) begin
          exp_ready = 1'b1;
          chk_fw    = 1'b1;
        end else begin
          // First cycle stalls, high half follows
          exp_ready = 1'b0;
          chk_fw    = 1'b0;
          @(negedge clk);
          exp_ready = 1'b1;
          exp_mc    = 1'b1;
          chk_fw    = 1'b1;
          wait_ready();
        end
      end
    end
    @(negedge clk);
    idle_inputs();
    finish_test("mult_ops", err0);
  endtask

  task automatic run_csr_stall();
    int err0;
    err0 = errors;
    // CSR data beats both multiplier and ALU
    @(negedge clk);
    alu_op     = ex_pkg::ALU_ADD;
    alu_a      = next_rand();
    alu_b      = next_rand();
    alu_en     = 1'b1;
    mul_op     = ex_pkg::MUL_L;
    mult_en    = 1'b1;
    csr_access = 1'b1;
    csr_rdata  = next_rand();
    exp_fw     = csr_rdata;
    exp_valid  = 1'b1;
    chk_fw     = 1'b1;
    chk_valid  = 1'b1;
    // WB back-pressure stalls the stage
    @(negedge clk);
    csr_access = 1'b0;
    mult_en    = 1'b0;
    wb_ready   = 1'b0;
    chk_fw     = 1'b0;
    exp_valid  = 1'b0;
    exp_ready  = 1'b0;
    exp_mc     = 1'b0;
    chk_ready  = 1'b1;
    // A branch still leaves EX
    @(negedge clk);
    branch_in_ex = 1'b1;
    exp_ready    = 1'b1;
    @(negedge clk);
    idle_inputs();
    finish_test("csr_stall", err0);
  endtask

  task automatic run_loads();
    int                     err0;
    logic [31:0]            rnd;
    logic [`EX_RADDR_W-1:0] addr0;
    err0 = errors;
    @(negedge clk);
    rnd       = next_rand();
    addr0     = rnd[5:0];
    lsu_en    = 1'b1;
    rf_we     = 1'b1;
    rf_waddr  = addr0;
    lsu_rdata = next_rand();
    exp_valid = 1'b1;
    chk_valid = 1'b1;
    // Load shows up one cycle after valid
    @(negedge clk);
    lsu_en       = 1'b0;
    rf_we        = 1'b0;
    chk_valid    = 1'b0;
    exp_we_wb    = 1'b1;
    exp_waddr_wb = addr0;
    chk_wb       = 1'b1;
    @(negedge clk);
    exp_we_wb = 1'b0;
    // Faulting load, no write and address untouched
    @(negedge clk);
    lsu_en   = 1'b1;
    rf_we    = 1'b1;
    lsu_err  = 1'b1;
    rf_waddr = ~addr0;
    @(negedge clk);
    lsu_en  = 1'b0;
    rf_we   = 1'b0;
    lsu_err = 1'b0;
    // Load held under back-pressure while the next ALU op waits in EX
    @(negedge clk);
    rnd       = next_rand();
    lsu_en    = 1'b1;
    rf_we     = 1'b1;
    rf_waddr  = rnd[5:0];
    lsu_rdata = next_rand();
    @(negedge clk);
    lsu_en       = 1'b0;
    rf_we        = 1'b0;
    alu_en       = 1'b1;
    wb_ready     = 1'b0;
    exp_we_wb    = 1'b1;
    exp_waddr_wb = rf_waddr;
    repeat (2) @(negedge clk);
    wb_ready = 1'b1;
    @(negedge clk);
    exp_we_wb = 1'b0;
    @(negedge clk);
    idle_inputs();
    finish_test("loads", err0);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    alu_op    = ex_pkg::ALU_ADD;
    alu_a     = '0;
    alu_b     = '0;
    alu_c     = '0;
    mul_op    = ex_pkg::MUL_L;
    mul_a     = '0;
    mul_b     = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    alu_waddr = '0;
    rf_waddr  = '0;
    idle_inputs();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_alu_ops();
    run_compares();
    run_mult_ops();
    run_csr_stall();
    run_loads();
    $display("Summary: %0d tests, %0d failed, %0d errors, timeout %b",
             tests_run, tests_failed, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_mult_tmr.sv
rtl/ex_stage.sv
sim/ex_stage_asserts.sv
sim/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f \
  --top-module ex_stage_tb --Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi
